// ==== verilog/br_cfg.svh ====
`ifndef BR_CFG_SVH
`define BR_CFG_SVH

// datapath width for pc, operands and targets
`define BR_XLEN 32

// predictor update queue between EX and the BTB
`define BR_UPD_FIFO_DEPTH 4

// direct-mapped BTB size, must stay a power of two
`define BR_BTB_ENTRIES 16

// pc bits below the BTB index, instructions are word aligned
`define BR_PC_ALIGN 2

`endif

// ==== verilog/br_pkg.sv ====
`include "br_cfg.svh"

package br_pkg;

    // branch kind as decoded in ID, LoongArch style
    typedef enum logic [3:0] {
        BR_NONE = 4'd0,                     // not a branch
        BR_JIRL = 4'd1,                     // register relative jump
        BR_B    = 4'd2,                     // unconditional pc relative
        BR_BL   = 4'd3,                     // call, pc relative
        BR_BEQ  = 4'd4,
        BR_BNE  = 4'd5,
        BR_BLT  = 4'd6,                     // signed compares
        BR_BGE  = 4'd7,
        BR_BLTU = 4'd8,                     // unsigned compares
        BR_BGEU = 4'd9
    } br_type_e;

    // class seen by the predictor
    typedef enum logic [1:0] {
        PD_NONE    = 2'd0,
        PD_COND    = 2'd1,                  // conditional branch
        PD_CALL    = 2'd2,                  // bl
        PD_RET_IND = 2'd3                   // jirl, return or indirect
    } pd_type_e;

    typedef struct packed {
        logic [`BR_XLEN-1:0] pc;            // pc of this slot
        logic [`BR_XLEN-1:0] rdata1;        // first source register
        logic [`BR_XLEN-1:0] rdata2;        // second source register
        logic [`BR_XLEN-1:0] imm;           // sign extended offset
        br_type_e            br_type;
        pd_type_e            pd_type;
        logic                pred_taken;    // front end direction guess
        logic [`BR_XLEN-1:0] pred_pc;       // front end target guess
    } ex_slot_t;

    typedef struct packed {
        logic                valid;         // flush and refetch strobe
        logic [`BR_XLEN-1:0] pc;            // refetch address
        logic                slot_a;        // redirect came from slot a
    } br_redirect_t;

    typedef struct packed {
        logic [`BR_XLEN-1:0] pc;            // branch pc, indexes the BTB
        pd_type_e            pd_type;
        logic [`BR_XLEN-1:0] target;        // computed target, taken or not
        logic                jump;          // real outcome
    } bp_update_t;

endpackage

// ==== verilog/branch_eval.sv ====
`timescale 1ns/1ns
`include "br_cfg.svh"

module branch_eval (
    input  br_pkg::ex_slot_t     slot,
    output logic                 taken,
    output logic [`BR_XLEN-1:0]  target
);
    import br_pkg::*;

    logic [`BR_XLEN:0]   diff;              // rdata1 - rdata2 with borrow bit
    logic                eq;                // operands equal
    logic                lt_u;              // unsigned less than
    logic                lt_s;              // signed less than
    logic                sign_differs;      // operand sign bits differ
    logic [`BR_XLEN-1:0] base;              // adder base, pc or rdata1

    // one subtractor for every compare
    assign diff = {1'b0, slot.rdata1} - {1'b0, slot.rdata2};
    assign eq   = (diff[`BR_XLEN-1:0] == '0);
    assign lt_u = diff[`BR_XLEN];           // borrow out

    // signed, with opposite signs the negative one is smaller
    assign sign_differs = slot.rdata1[`BR_XLEN-1] ^ slot.rdata2[`BR_XLEN-1];
    assign lt_s = sign_differs ? slot.rdata1[`BR_XLEN-1] : diff[`BR_XLEN-1];

    always_comb begin
        case (slot.br_type)
            BR_JIRL,
            BR_B,
            BR_BL:   taken = 1'b1;          // always jump
            BR_BEQ:  taken = eq;
            BR_BNE:  taken = ~eq;
            BR_BLT:  taken = lt_s;
            BR_BGE:  taken = ~lt_s;
            BR_BLTU: taken = lt_u;
            BR_BGEU: taken = ~lt_u;
            default: taken = 1'b0;          // none and unused codes
        endcase
    end

    // jirl is register relative, all others pc relative
    assign base   = (slot.br_type == BR_JIRL) ? slot.rdata1 : slot.pc;
    assign target = base + slot.imm;

endmodule

// ==== verilog/fu_br.sv ====
`timescale 1ns/1ns
`include "br_cfg.svh"

module fu_br (
    input  br_pkg::ex_slot_t     slot_a,
    input  br_pkg::ex_slot_t     slot_b,
    input  logic                 stall_dcache_buf,
    input  logic                 stall_div_buf,
    output br_pkg::br_redirect_t redirect,
    output logic                 upd_valid,
    output br_pkg::bp_update_t   upd
);
    import br_pkg::*;

    localparam logic [`BR_XLEN-1:0] INSN_BYTES = 4;  // fall through step

    logic                taken_a;       // real outcome of slot a
    logic                taken_b;
    logic [`BR_XLEN-1:0] target_a;      // real target of slot a
    logic [`BR_XLEN-1:0] target_b;
    logic                mis_a;         // slot a guessed wrong
    logic                mis_b;
    logic [`BR_XLEN-1:0] fix_pc_a;      // where slot a should have gone
    logic [`BR_XLEN-1:0] fix_pc_b;
    logic                no_stall;      // both buffered stalls low
    logic                upd_sel_b;     // update describes slot b
    pd_type_e            upd_type_raw;  // selected class before stall gate

    branch_eval eval_a (
        .slot   (slot_a),
        .taken  (taken_a),
        .target (target_a)
    );

    branch_eval eval_b (
        .slot   (slot_b),
        .taken  (taken_b),
        .target (target_b)
    );

    // wrong direction or wrong pc on a real branch
    assign mis_a = (slot_a.br_type != BR_NONE) &&
                   ((slot_a.pred_taken != taken_a) || (slot_a.pred_pc != target_a));
    assign mis_b = (slot_b.br_type != BR_NONE) &&
                   ((slot_b.pred_taken != taken_b) || (slot_b.pred_pc != target_b));

    assign fix_pc_a = taken_a ? target_a : slot_a.pc + INSN_BYTES;
    assign fix_pc_b = taken_b ? target_b : slot_b.pc + INSN_BYTES;

    // a stalled EX would redirect again on every held cycle
    assign no_stall = ~stall_dcache_buf & ~stall_div_buf;

    // older slot a wins
    assign redirect.valid  = (mis_a | mis_b) & no_stall;
    assign redirect.pc     = mis_a ? fix_pc_a : fix_pc_b;
    assign redirect.slot_a = mis_a;

    // slot a feeds the predictor first if it is a predicted branch
    assign upd_sel_b    = (slot_a.pd_type == PD_NONE);
    assign upd_type_raw = upd_sel_b ? slot_b.pd_type : slot_a.pd_type;

    assign upd.pc      = upd_sel_b ? slot_b.pc : slot_a.pc;
    assign upd.target  = upd_sel_b ? target_b  : target_a;
    assign upd.jump    = upd_sel_b ? taken_b   : taken_a;
    assign upd.pd_type = no_stall ? upd_type_raw : PD_NONE;   // class dropped under stall

    // push only a record whose class survived the stall gate
    assign upd_valid = (upd.pd_type != PD_NONE);

endmodule

// ==== verilog/bp_update_fifo.sv ====
`timescale 1ns/1ns
`include "br_cfg.svh"

module bp_update_fifo (
    input  logic               clk,
    input  logic               rst,
    input  logic               push,
    input  br_pkg::bp_update_t push_data,
    output logic               wr_valid,
    output br_pkg::bp_update_t wr_data,
    input  logic               wr_ready,
    output logic               overflow
);
    import br_pkg::*;

    localparam int DEPTH = `BR_UPD_FIFO_DEPTH;
    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    bp_update_t       mem [DEPTH];      // payload only, no reset
    logic [PTR_W-1:0] wr_ptr;           // next free slot
    logic [PTR_W-1:0] rd_ptr;           // head
    logic [CNT_W-1:0] count;            // occupied entries
    logic             full;
    logic             pop;              // head taken by the BTB this cycle
    logic             push_ok;          // push that gets stored

    assign full     = (count == CNT_W'(DEPTH));
    assign wr_valid = (count != '0);
    assign wr_data  = mem[rd_ptr];
    assign pop      = wr_valid & wr_ready;
    assign push_ok  = push & (~full | pop);   // full plus pop frees a slot

    always_ff @(posedge clk) begin
        if (push_ok) begin
            mem[wr_ptr] <= push_data;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            count    <= '0;
            overflow <= 1'b0;
        end else begin
            if (push_ok) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({push_ok, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;        // idle or push with pop
            endcase
            if (push && !push_ok) begin
                overflow <= 1'b1;               // sticky until reset
            end
        end
    end

endmodule

// ==== verilog/btb_table.sv ====
`timescale 1ns/1ns
`include "br_cfg.svh"

module btb_table (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 wr_valid,
    input  br_pkg::bp_update_t   wr_data,
    output logic                 wr_ready,
    input  logic                 lookup_en,
    input  logic [`BR_XLEN-1:0]  lookup_pc,
    output logic                 hit,
    output logic [`BR_XLEN-1:0]  hit_target,
    output logic                 hit_jump,
    output br_pkg::pd_type_e     hit_type
);
    import br_pkg::*;

    localparam int ENTRIES = `BR_BTB_ENTRIES;
    localparam int IDX_W   = $clog2(ENTRIES);
    localparam int IDX_LO  = `BR_PC_ALIGN;          // skip byte offset
    localparam int TAG_LO  = IDX_LO + IDX_W;
    localparam int TAG_W   = `BR_XLEN - TAG_LO;

    typedef struct packed {
        logic [TAG_W-1:0]    tag;               // upper pc bits
        logic [`BR_XLEN-1:0] target;
        logic                jump;              // last outcome only
        pd_type_e            pd_type;
    } btb_entry_t;

    btb_entry_t         table_q [ENTRIES];      // payload, no reset
    logic [ENTRIES-1:0] valid_q;                // cleared on reset

    logic               wr_en;                  // drain one FIFO entry
    logic [IDX_W-1:0]   wr_idx;
    btb_entry_t         wr_entry;
    logic [IDX_W-1:0]   rd_idx;
    btb_entry_t         rd_entry;
    logic               tag_match;

    // lookups own the single port, writes wait
    assign wr_ready = ~lookup_en;
    assign wr_en    = wr_valid & wr_ready;
    assign wr_idx   = wr_data.pc[TAG_LO-1:IDX_LO];

    assign wr_entry.tag     = wr_data.pc[`BR_XLEN-1:TAG_LO];
    assign wr_entry.target  = wr_data.target;
    assign wr_entry.jump    = wr_data.jump;
    assign wr_entry.pd_type = wr_data.pd_type;

    always_ff @(posedge clk) begin
        if (wr_en) begin
            table_q[wr_idx] <= wr_entry;        // replace whatever was there
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q <= '0;
        end else if (wr_en) begin
            valid_q[wr_idx] <= 1'b1;
        end
    end

    // combinational read
    assign rd_idx    = lookup_pc[TAG_LO-1:IDX_LO];
    assign rd_entry  = table_q[rd_idx];
    assign tag_match = (rd_entry.tag == lookup_pc[`BR_XLEN-1:TAG_LO]);

    assign hit = lookup_en & valid_q[rd_idx] & tag_match;

    // outputs quiet on a miss
    assign hit_target = hit ? rd_entry.target : '0;
    assign hit_jump   = hit & rd_entry.jump;
    assign hit_type   = hit ? rd_entry.pd_type : PD_NONE;

endmodule

// ==== verilog/ex_branch_top.sv ====
`timescale 1ns/1ns
`include "br_cfg.svh"

module ex_branch_top (
    input  logic                 clk,
    input  logic                 rst,
    input  br_pkg::ex_slot_t     slot_a,
    input  br_pkg::ex_slot_t     slot_b,
    input  logic                 stall_dcache_buf,
    input  logic                 stall_div_buf,
    input  logic                 lookup_en,
    input  logic [`BR_XLEN-1:0]  lookup_pc,
    output br_pkg::br_redirect_t redirect,
    output logic                 overflow,
    output logic                 hit,
    output logic [`BR_XLEN-1:0]  hit_target,
    output logic                 hit_jump,
    output br_pkg::pd_type_e     hit_type
);
    import br_pkg::*;

    logic       upd_valid;      // EX update strobe
    bp_update_t upd;            // EX update record
    logic       wr_valid;       // FIFO head present
    bp_update_t wr_data;        // FIFO head
    logic       wr_ready;       // BTB free this cycle

    fu_br u_fu_br (
        .slot_a           (slot_a),
        .slot_b           (slot_b),
        .stall_dcache_buf (stall_dcache_buf),
        .stall_div_buf    (stall_div_buf),
        .redirect         (redirect),
        .upd_valid        (upd_valid),
        .upd              (upd)
    );

    bp_update_fifo u_upd_fifo (
        .clk       (clk),
        .rst       (rst),
        .push      (upd_valid),
        .push_data (upd),
        .wr_valid  (wr_valid),
        .wr_data   (wr_data),
        .wr_ready  (wr_ready),
        .overflow  (overflow)
    );

    btb_table u_btb (
        .clk        (clk),
        .rst        (rst),
        .wr_valid   (wr_valid),
        .wr_data    (wr_data),
        .wr_ready   (wr_ready),
        .lookup_en  (lookup_en),
        .lookup_pc  (lookup_pc),
        .hit        (hit),
        .hit_target (hit_target),
        .hit_jump   (hit_jump),
        .hit_type   (hit_type)
    );

endmodule

// ==== dv/tb_ex_branch.sv ====
`timescale 1ns/1ns
`include "br_cfg.svh"

module tb_ex_branch;
    import br_pkg::*;

    localparam int IDLE_CYCLES = `BR_UPD_FIFO_DEPTH + 3;   // enough to drain the FIFO
    localparam logic [31:0] LFSR_TAPS = 32'h80200003;

    logic                 clk;
    logic                 rst;
    ex_slot_t             slot_a;
    ex_slot_t             slot_b;
    logic                 stall_dcache_buf;
    logic                 stall_div_buf;
    logic                 lookup_en;
    logic [`BR_XLEN-1:0]  lookup_pc;
    br_redirect_t         redirect;
    logic                 overflow;
    logic                 hit;
    logic [`BR_XLEN-1:0]  hit_target;
    logic                 hit_jump;
    pd_type_e             hit_type;

    logic [31:0]    lfsr;                   // random operand source
    logic [31:0]    fld [8];                // numeric fields of the current line
    int             n_lines;                // case file length, sizes the watchdog
    int             n_checks;
    int             n_err;
    int             test_err;               // errors in the running test
    int             n_pass;
    int             n_fail;
    logic           test_active;
    logic [8*32-1:0] test_name;

    ex_branch_top dut (
        .clk              (clk),
        .rst              (rst),
        .slot_a           (slot_a),
        .slot_b           (slot_b),
        .stall_dcache_buf (stall_dcache_buf),
        .stall_div_buf    (stall_div_buf),
        .lookup_en        (lookup_en),
        .lookup_pc        (lookup_pc),
        .redirect         (redirect),
        .overflow         (overflow),
        .hit              (hit),
        .hit_target       (hit_target),
        .hit_jump         (hit_jump),
        .hit_type         (hit_type)
    );

    always #10 clk = ~clk;                  // 20 ns period

    // galois step, one output bit per call
    function automatic logic lfsr_bit();
        logic b;
        b    = lfsr[0];
        lfsr = lfsr >> 1;
        if (b) lfsr = lfsr ^ LFSR_TAPS;
        return b;
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) r = {r[30:0], lfsr_bit()};
        return r;
    endfunction

    function automatic logic model_taken(input ex_slot_t s);
        case (s.br_type)
            BR_JIRL, BR_B, BR_BL: return 1'b1;
            BR_BEQ:  return s.rdata1 == s.rdata2;
            BR_BNE:  return s.rdata1 != s.rdata2;
            BR_BLT:  return $signed(s.rdata1) < $signed(s.rdata2);
            BR_BGE:  return $signed(s.rdata1) >= $signed(s.rdata2);
            BR_BLTU: return s.rdata1 < s.rdata2;
            BR_BGEU: return s.rdata1 >= s.rdata2;
            default: return 1'b0;
        endcase
    endfunction

    function automatic logic [31:0] model_target(input ex_slot_t s);
        return (s.br_type == BR_JIRL) ? s.rdata1 + s.imm : s.pc + s.imm;
    endfunction

    function automatic br_redirect_t model_redirect(input ex_slot_t a, input ex_slot_t b,
                                                    input logic sd, input logic sv);
        br_redirect_t r;
        logic         ma;
        logic         mb;
        logic [31:0]  ca;
        logic [31:0]  cb;
        ma = (a.br_type != BR_NONE) &&
             ((a.pred_taken != model_taken(a)) || (a.pred_pc != model_target(a)));
        mb = (b.br_type != BR_NONE) &&
             ((b.pred_taken != model_taken(b)) || (b.pred_pc != model_target(b)));
        ca = model_taken(a) ? model_target(a) : a.pc + 32'd4;    // taken or fall through
        cb = model_taken(b) ? model_target(b) : b.pc + 32'd4;
        r.valid  = (ma || mb) && !sd && !sv;
        r.pc     = ma ? ca : cb;            // older slot first
        r.slot_a = ma;
        return r;
    endfunction

    function automatic ex_slot_t make_slot();
        ex_slot_t s;
        s.pc         = fld[0];
        s.rdata1     = fld[1];
        s.rdata2     = fld[2];
        s.imm        = fld[3];
        s.br_type    = br_type_e'(fld[4][3:0]);
        s.pd_type    = pd_type_e'(fld[5][1:0]);
        s.pred_taken = fld[6][0];
        s.pred_pc    = fld[7];
        return s;
    endfunction

    task automatic rand_slot(output ex_slot_t s);
        logic [31:0] t;
        s.pc      = rand_bits(30) << 2;
        t         = rand_bits(4) % 10;      // all kinds, none included
        s.br_type = br_type_e'(t[3:0]);
        t         = rand_bits(2);
        s.pd_type = pd_type_e'(t[1:0]);
        s.rdata1  = rand_bits(32);
        s.rdata2  = (rand_bits(2) == 0) ? s.rdata1 : rand_bits(32);   // hit the equal case
        t         = rand_bits(16);
        s.imm     = {{16{t[15]}}, t[15:0]};
        t         = rand_bits(1);
        s.pred_taken = t[0];
        t         = rand_bits(1);
        s.pred_pc = t[0] ? model_target(s) : rand_bits(32);
    endtask

    task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
        n_checks++;
        assert (got === exp) else begin
            $display("FAIL %0s got %h expected %h", name, got, exp);
            n_err++;
            test_err++;
        end
    endtask

    // drive at the falling edge, compare one cycle later
    task automatic run_cycle(input ex_slot_t a, input ex_slot_t b, input logic sd, input logic sv);
        br_redirect_t m;
        slot_a           = a;
        slot_b           = b;
        stall_dcache_buf = sd;
        stall_div_buf    = sv;
        @(negedge clk);
        m = model_redirect(a, b, sd, sv);
        check_val("redirect.valid", 32'(redirect.valid), 32'(m.valid));
        if (m.valid) begin
            check_val("redirect.pc", redirect.pc, m.pc);
            check_val("redirect.slot_a", 32'(redirect.slot_a), 32'(m.slot_a));
        end
    endtask

    task automatic lookup_check();
        lookup_en = 1'b0;
        repeat (IDLE_CYCLES) @(negedge clk);    // let queued updates land
        lookup_en = 1'b1;
        lookup_pc = fld[0];
        @(negedge clk);
        check_val("hit", 32'(hit), fld[1]);
        check_val("hit_target", hit_target, fld[2]);
        check_val("hit_jump", 32'(hit_jump), fld[3]);
        check_val("hit_type", 32'(hit_type), fld[4]);
        lookup_en = 1'b0;
    endtask

    task automatic finish_test();
        if (test_active) begin
            if (test_err == 0) begin
                n_pass++;
                $display("test %0s: pass", test_name);
            end else begin
                n_fail++;
                $display("test %0s: fail, %0d bad checks", test_name, test_err);
            end
        end
    endtask

    initial begin
        wait (n_lines > 0);
        #((n_lines * 40 + 200) * 20);
        $display("timeout, the case file did not complete in time");
        $display("ERRORS FOUND");
        $finish;
    end

    initial begin
        int             fd;
        int             r;
        logic [63:0]    tok;
        logic [8*256-1:0] line;
        ex_slot_t       pend_a;             // slots staged for the next R line
        ex_slot_t       pend_b;
        ex_slot_t       ra;
        ex_slot_t       rb;
        clk = 1'b0;
        rst = 1'b1;
        slot_a = '0;
        slot_b = '0;
        stall_dcache_buf = 1'b0;
        stall_div_buf = 1'b0;
        lookup_en = 1'b0;
        lookup_pc = '0;
        lfsr = 32'd49;
        pend_a = '0;
        pend_b = '0;
        n_lines = 0;
        n_checks = 0;
        n_err = 0;
        test_err = 0;
        n_pass = 0;
        n_fail = 0;
        test_active = 1'b0;
        fd = $fopen("dv/br_cases.txt", "r");
        if (fd == 0) begin
            $display("cannot open dv/br_cases.txt");
            n_err++;
        end else begin
            while (!$feof(fd)) begin
                if ($fgets(line, fd) > 0) n_lines++;
            end
            $fclose(fd);
            fd = $fopen("dv/br_cases.txt", "r");
        end
        repeat (8) @(negedge clk);
        rst = 1'b0;
        while (fd != 0) begin
            r = $fscanf(fd, " %s", tok);
            if (r != 1) break;
            case (tok)
                "#": r = $fgets(line, fd);
                "T": begin
                    finish_test();
                    r = $fscanf(fd, " %s", test_name);
                    test_active = 1'b1;
                    test_err = 0;
                end
                "A", "B": begin
                    r = $fscanf(fd, " %h %h %h %h %h %h %h %h", fld[0], fld[1], fld[2],
                                fld[3], fld[4], fld[5], fld[6], fld[7]);
                    if (tok == "A") pend_a = make_slot();
                    else pend_b = make_slot();
                end
                "R": begin
                    r = $fscanf(fd, " %h %h %h %h %h", fld[0], fld[1], fld[2], fld[3], fld[4]);
                    run_cycle(pend_a, pend_b, fld[0][0], fld[1][0]);
                    check_val("redirect.valid", 32'(redirect.valid), fld[2]);
                    if (fld[2][0]) begin
                        check_val("redirect.pc", redirect.pc, fld[3]);
                        check_val("redirect.slot_a", 32'(redirect.slot_a), fld[4]);
                    end
                    pend_a = '0;
                    pend_b = '0;
                    slot_a = '0;
                    slot_b = '0;
                    stall_dcache_buf = 1'b0;
                    stall_div_buf = 1'b0;
                end
                "L": begin
                    r = $fscanf(fd, " %h %h %h %h %h", fld[0], fld[1], fld[2], fld[3], fld[4]);
                    lookup_check();
                end
                "K": begin
                    r = $fscanf(fd, " %h %h", fld[0], fld[1]);
                    lookup_en = fld[0][0];
                    lookup_pc = fld[1];
                end
                "O": begin
                    r = $fscanf(fd, " %h", fld[0]);
                    check_val("overflow", 32'(overflow), fld[0]);
                end
                "Z": begin
                    rst = 1'b1;
                    repeat (8) @(negedge clk);
                    rst = 1'b0;
                end
                "X": begin
                    r = $fscanf(fd, " %h", fld[0]);
                    for (int i = 0; i < int'(fld[0]); i++) begin
                        rand_slot(ra);
                        rand_slot(rb);
                        run_cycle(ra, rb, rand_bits(3) == 0, rand_bits(3) == 0);
                    end
                    slot_a = '0;
                    slot_b = '0;
                    stall_dcache_buf = 1'b0;
                    stall_div_buf = 1'b0;
                end
                default: begin
                    $display("unknown command %0s in the case file", tok);
                    n_err++;
                    test_err++;
                end
            endcase
        end
        finish_test();
        $display("tests passed %0d failed %0d, checks %0d, errors %0d",
                 n_pass, n_fail, n_checks, n_err);
        if (n_err == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

// ==== dv/br_cases.txt ====
# T name | A or B pc rdata1 rdata2 imm br_type pd_type pred_taken pred_pc | R stall_dc stall_div valid pc slot_a
# L pc hit target jump type | K lookup_en lookup_pc | O overflow | Z reset | X random cycles
T branch_types
A 00001000 00002000 00000000 00000010 1 0 0 00000000
R 0 0 1 00002010 1
A 00001100 00000000 00000000 fffffff0 2 0 0 00000000
R 0 0 1 000010f0 1
A 00001200 00000000 00000000 00000400 3 0 0 00000000
R 0 0 1 00001600 1
A 00001300 00000005 00000005 00000020 4 0 0 00000000
R 0 0 1 00001320 1
A 00001400 00000007 00000007 00000020 5 0 1 00001420
R 0 0 1 00001404 1
A 00001500 ffffffff 00000001 00000040 6 0 0 00000000
R 0 0 1 00001540 1
A 00001600 ffffffff 00000001 00000040 8 0 1 00001640
R 0 0 1 00001604 1
A 00001700 80000000 7fffffff 00000008 7 0 1 00001708
R 0 0 1 00001704 1
A 00001800 80000000 7fffffff 00000008 9 0 0 00000000
R 0 0 1 00001808 1
T predict_match
A 00002000 00000003 00000003 00000010 4 0 1 00002010
R 0 0 0 00000000 0
A 00002100 00000003 00000003 00000010 4 0 1 00002200
R 0 0 1 00002110 1
A 00002200 00000003 00000003 00000010 5 0 1 00002210
R 0 0 1 00002204 1
A 00002300 00000003 00000003 00000010 5 0 0 00002310
R 0 0 0 00000000 0
T slot_priority
A 00003000 00000000 00000000 00000100 2 0 0 00000000
B 00003004 00000000 00000000 00000200 3 0 0 00000000
R 0 0 1 00003100 1
A 00003000 00000000 00000000 00000000 0 0 1 00009999
B 00003100 00000000 00000000 00000008 2 0 0 00000000
R 0 0 1 00003108 0
A 00003200 00000000 00000000 00000000 0 0 1 00001234
B 00003204 00000000 00000000 00000000 0 0 1 00005678
R 0 0 0 00000000 0
T stall_gate
A 00004000 00000000 00000000 00000040 3 2 0 00000000
R 1 0 0 00000000 0
A 00004100 00000000 00000000 00000040 3 2 0 00000000
R 0 1 0 00000000 0
L 00004000 0 00000000 0 0
L 00004100 0 00000000 0 0
T btb_update
A 00005000 00000001 00000002 00000030 4 1 0 00005030
R 0 0 0 00000000 0
B 00005104 00000000 00000000 00000100 3 2 1 00005204
R 0 0 0 00000000 0
A 00005008 00000001 00000002 00000010 5 1 1 00005018
B 00005300 00000000 00000000 00000004 3 2 1 00005304
R 0 0 0 00000000 0
L 00005000 1 00005030 0 1
L 00005104 1 00005204 1 2
L 00005008 1 00005018 1 1
L 00005300 0 00000000 0 0
T fifo_overflow
Z
K 1 00000000
A 00006000 00000000 00000000 00000020 4 1 1 00006020
R 0 0 0 00000000 0
A 00006004 00000000 00000000 00000020 4 1 1 00006024
R 0 0 0 00000000 0
A 00006008 00000000 00000000 00000020 4 1 1 00006028
R 0 0 0 00000000 0
A 0000600c 00000000 00000000 00000020 4 1 1 0000602c
R 0 0 0 00000000 0
A 00006010 00000000 00000000 00000020 4 1 1 00006030
R 0 0 0 00000000 0
O 1
K 0 00000000
L 00006000 1 00006020 1 1
L 0000600c 1 0000602c 1 1
L 00006010 0 00000000 0 0
T random_slots
Z
X 20

// ==== project.f ====
+incdir+verilog
verilog/br_pkg.sv
verilog/branch_eval.sv
verilog/fu_br.sv
verilog/bp_update_fifo.sv
verilog/btb_table.sv
verilog/ex_branch_top.sv
dv/tb_ex_branch.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the branch unit testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f project.f --top-module tb_ex_branch -o sim_tb

./obj_dir/sim_tb | tee sim.log

if grep -q "ERRORS FOUND" sim.log; then
    echo "simulation failed"
    exit 1
fi
echo "simulation passed"
